/* verilog.f */
source/apb_pkg.sv
source/cache_pkg.sv
source/cache_if.sv
source/dp_ram.sv
source/cache.sv
source/cache_ctrl.sv
source/cache_top.sv
verif/tb_clkgen.sv
verif/tb_cache_top.sv

/* verif/tb_cache_top.sv */
// Cache subsystem testbench

`timescale 1ns/1ps

module tb_cache_top import apb_pkg::*; ();

    localparam DATA_WIDTH    = 32;
    localparam ADDR_WIDTH    = 16;
    localparam INDEX_COUNT   = 16;
    localparam LINE_WORDS    = 4;
    localparam MEM_WORDS     = 1 << (ADDR_WIDTH - 2);
    localparam NUM_TRANSFERS = 240;
    localparam MISS_CYCLES   = 16 * 5 + 4;
    localparam CYCLE_LIMIT   = NUM_TRANSFERS * MISS_CYCLES * 2;
    localparam SEED          = 32'd79983;

    logic                  clk;
    logic                  n_rst;
    logic                  i_psel;
    logic                  i_penable;
    logic                  i_pwrite;
    logic [ADDR_WIDTH-1:0] i_paddr;
    logic [DATA_WIDTH-1:0] i_pwdata;
    logic [DATA_WIDTH-1:0] o_prdata;
    logic                  o_pready;
    logic                  o_pslverr;
    logic                  o_mem_psel;
    logic                  o_mem_penable;
    logic                  o_mem_pwrite;
    logic [ADDR_WIDTH-1:0] o_mem_paddr;
    logic [DATA_WIDTH-1:0] o_mem_pwdata;
    logic [DATA_WIDTH-1:0] i_mem_prdata;
    logic                  i_mem_pready;

    // memory model state
    logic [DATA_WIDTH-1:0] mem_model [MEM_WORDS];
    apb_phase_t            mem_phase;
    int                    wait_left;
    logic [31:0]           wait_rng;
    int                    mem_reads;
    int                    mem_writes;

    // reference model of memory and cache contents
    logic [DATA_WIDTH-1:0] ref_mem [MEM_WORDS];
    logic [7:0]            ref_tag [INDEX_COUNT];
    logic                  ref_valid [INDEX_COUNT];
    logic                  ref_dirty [INDEX_COUNT];
    logic [DATA_WIDTH-1:0] ref_line [INDEX_COUNT][LINE_WORDS];
    int                    exp_reads;
    int                    exp_writes;

    logic [31:0]           stim_rng;
    int                    cycle_count = 0;

    tb_clkgen #(.PERIOD(100)) u_clkgen (.clk(clk));

    cache_top #(
        .DATA_WIDTH     (DATA_WIDTH),
        .ADDR_WIDTH     (ADDR_WIDTH),
        .CACHE_SIZE     (256),
        .CACHE_LINE_SIZE(16)
    ) u_dut (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .o_mem_psel   (o_mem_psel),
        .o_mem_penable(o_mem_penable),
        .o_mem_pwrite (o_mem_pwrite),
        .o_mem_paddr  (o_mem_paddr),
        .o_mem_pwdata (o_mem_pwdata),
        .i_mem_prdata (i_mem_prdata),
        .i_mem_pready (i_mem_pready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // the initial memory word is built from every bit of its byte address
    function automatic logic [31:0] fill_word(input logic [15:0] addr);
        return {addr ^ 16'hc3a5, addr};
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // the memory side APB slave answers from mem_model after 0 to 2 wait states
    always @(negedge clk) begin
        if (!n_rst) begin
            i_mem_pready = 1'b0;
            wait_left    = -1;
        end else begin
            mem_phase    = !o_mem_psel ? PH_IDLE : (o_mem_penable ? PH_ACCESS : PH_SETUP);
            i_mem_pready = 1'b0;
            if (mem_phase == PH_ACCESS) begin
                if (wait_left < 0) begin
                    wait_rng  = xorshift32(wait_rng);
                    wait_left = wait_rng % 3;
                end
                if (wait_left == 0) begin
                    // the transfer completes on the coming rising edge
                    i_mem_pready = 1'b1;
                    wait_left    = -1;
                    if (o_mem_pwrite) begin
                        mem_model[o_mem_paddr[ADDR_WIDTH-1:2]] = o_mem_pwdata;
                        mem_writes++;
                    end else begin
                        i_mem_prdata = mem_model[o_mem_paddr[ADDR_WIDTH-1:2]];
                        mem_reads++;
                    end
                end else begin
                    wait_left--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("ERROR: the run passed %0d cycles without finishing", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    // write-allocate update of the reference model that also counts the expected line traffic
    task automatic ref_access(input logic write, input logic [15:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        logic [7:0] tag;
        logic [3:0] idx;
        logic [1:0] word;
        tag   = addr[15:8];
        idx   = addr[7:4];
        word  = addr[3:2];
        rdata = '0;
        if (!(ref_valid[idx] && ref_tag[idx] == tag)) begin
            if (ref_valid[idx] && ref_dirty[idx]) begin
                for (int w = 0; w < LINE_WORDS; w++) begin
                    ref_mem[{ref_tag[idx], idx, 2'(w)}] = ref_line[idx][w];
                end
                exp_writes += LINE_WORDS;
            end
            for (int w = 0; w < LINE_WORDS; w++) begin
                ref_line[idx][w] = ref_mem[{tag, idx, 2'(w)}];
            end
            exp_reads     += LINE_WORDS;
            ref_tag[idx]   = tag;
            ref_valid[idx] = 1'b1;
            ref_dirty[idx] = 1'b0;
        end
        if (write) begin
            ref_line[idx][word] = wdata;
            ref_dirty[idx]      = 1'b1;
        end else begin
            rdata = ref_line[idx][word];
        end
    endtask

    // one CPU APB transfer where cycles counts the access cycles up to and including pready
    task automatic apb_transfer(input logic write, input logic [15:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic slverr, output int cycles);
        @(negedge clk);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = write;
        i_paddr   = addr;
        i_pwdata  = wdata;
        @(negedge clk);
        i_penable = 1'b1;
        cycles    = 1;
        while (!o_pready) begin
            @(negedge clk);
            cycles++;
        end
        rdata  = o_prdata;
        slverr = o_pslverr;
        @(negedge clk);
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic cpu_access(input logic write, input logic [15:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output int cycles);
        logic [31:0] exp_rdata;
        logic        slverr;
        ref_access(write, addr, wdata, exp_rdata);
        apb_transfer(write, addr, wdata, rdata, slverr, cycles);
        check_equal(slverr, 1'b0, $sformatf("pslverr on aligned access to %h", addr));
        if (!write) begin
            check_equal(rdata, exp_rdata, $sformatf("read data at %h", addr));
        end
        check_equal(mem_reads, exp_reads, "memory read transfer count");
        check_equal(mem_writes, exp_writes, "memory write transfer count");
    endtask

    task automatic read_miss();
        logic [31:0] rdata;
        int          cycles;
        int          reads0;
        int          writes0;
        reads0  = mem_reads;
        writes0 = mem_writes;
        cpu_access(1'b0, 16'h1234, '0, rdata, cycles);
        check_equal(rdata, fill_word(16'h1234), "read miss data");
        check_equal(mem_reads - reads0, 4, "read miss memory reads");
        check_equal(mem_writes - writes0, 0, "read miss memory writes");
    endtask

    task automatic read_hit();
        logic [31:0] rdata;
        int          cycles;
        int          traffic0;
        traffic0 = mem_reads + mem_writes;
        cpu_access(1'b0, 16'h1238, '0, rdata, cycles);
        check_equal(rdata, fill_word(16'h1238), "read hit data");
        check_equal(mem_reads + mem_writes - traffic0, 0, "read hit memory traffic");
        check_equal(cycles, 2, "read hit access cycles");
    endtask

    task automatic write_hit();
        logic [31:0] rdata;
        int          cycles;
        int          traffic0;
        traffic0 = mem_reads + mem_writes;
        cpu_access(1'b1, 16'h1238, 32'hdeadbeef, rdata, cycles);
        cpu_access(1'b0, 16'h1238, '0, rdata, cycles);
        check_equal(rdata, 32'hdeadbeef, "read after write hit");
        check_equal(mem_reads + mem_writes - traffic0, 0, "write hit memory traffic");
        check_equal(mem_model[16'h1238 >> 2], fill_word(16'h1238), "memory after write hit");
    endtask

    task automatic dirty_eviction();
        logic [31:0] rdata;
        int          cycles;
        int          reads0;
        int          writes0;
        reads0  = mem_reads;
        writes0 = mem_writes;
        // same index as 0x1238 with a different tag
        cpu_access(1'b0, 16'h5534, '0, rdata, cycles);
        check_equal(rdata, fill_word(16'h5534), "read after eviction");
        check_equal(mem_writes - writes0, 4, "eviction memory writes");
        check_equal(mem_reads - reads0, 4, "eviction memory reads");
        check_equal(mem_model[16'h1238 >> 2], 32'hdeadbeef, "written word in memory");
        check_equal(mem_model[16'h1234 >> 2], fill_word(16'h1234), "clean word in memory");
    endtask

    task automatic unaligned_access();
        logic [31:0] rdata;
        logic        slverr;
        int          cycles;
        int          traffic0;
        traffic0 = mem_reads + mem_writes;
        apb_transfer(1'b0, 16'h5535, '0, rdata, slverr, cycles);
        check_equal(slverr, 1'b1, "pslverr on unaligned read");
        check_equal(cycles, 1, "unaligned read access cycles");
        apb_transfer(1'b1, 16'h553a, 32'h01234567, rdata, slverr, cycles);
        check_equal(slverr, 1'b1, "pslverr on unaligned write");
        cpu_access(1'b0, 16'h5538, '0, rdata, cycles);
        check_equal(rdata, fill_word(16'h5538), "read after unaligned write");
        check_equal(mem_reads + mem_writes - traffic0, 0, "unaligned memory traffic");
    endtask

    task automatic random_mix();
        logic [31:0] rdata;
        logic [31:0] r;
        logic [15:0] addr;
        int          cycles;
        for (int n = 0; n < 200; n++) begin
            stim_rng = xorshift32(stim_rng);
            r        = stim_rng;
            // four tags over four indexes keeps conflicts frequent
            addr     = {6'd0, r[5:4], 2'd0, r[7:6], r[9:8], 2'b00};
            stim_rng = xorshift32(stim_rng);
            cpu_access(r[0], addr, stim_rng, rdata, cycles);
        end
        for (int idx = 0; idx < INDEX_COUNT; idx++) begin
            if (ref_valid[idx] && ref_dirty[idx]) begin
                cpu_access(1'b0, {8'hf0, 4'(idx), 4'h0}, '0, rdata, cycles);
            end
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_equal(mem_model[i], ref_mem[i], $sformatf("final memory word %0d", i));
        end
    endtask

    initial begin
        n_rst        = 1'b0;
        i_psel       = 1'b0;
        i_penable    = 1'b0;
        i_pwrite     = 1'b0;
        i_paddr      = '0;
        i_pwdata     = '0;
        i_mem_prdata = '0;
        i_mem_pready = 1'b0;
        wait_left    = -1;
        wait_rng     = SEED;
        stim_rng     = SEED;
        mem_reads    = 0;
        mem_writes   = 0;
        exp_reads    = 0;
        exp_writes   = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = fill_word(16'(i << 2));
            ref_mem[i]   = fill_word(16'(i << 2));
        end
        for (int idx = 0; idx < INDEX_COUNT; idx++) begin
            ref_tag[idx]   = '0;
            ref_valid[idx] = 1'b0;
            ref_dirty[idx] = 1'b0;
        end
        repeat (8) @(negedge clk);
        n_rst = 1'b1;

        read_miss();
        read_hit();
        write_hit();
        dirty_eviction();
        unaligned_access();
        random_mix();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* verif/tb_clkgen.sv */
// Testbench clock source

`timescale 1ns/1ps

module tb_clkgen #(
    parameter PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

/* source/cache_top.sv */
// Cache subsystem top level

`timescale 1ns/1ps

module cache_top #(
    parameter DATA_WIDTH      = 32,
    parameter ADDR_WIDTH      = 16,
    parameter CACHE_SIZE      = 256,
    parameter CACHE_LINE_SIZE = 16
) (
    input  logic                  clk,
    input  logic                  n_rst,

    input  logic                  i_psel,
    input  logic                  i_penable,
    input  logic                  i_pwrite,
    input  logic [ADDR_WIDTH-1:0] i_paddr,
    input  logic [DATA_WIDTH-1:0] i_pwdata,
    output logic [DATA_WIDTH-1:0] o_prdata,
    output logic                  o_pready,
    output logic                  o_pslverr,

    output logic                  o_mem_psel,
    output logic                  o_mem_penable,
    output logic                  o_mem_pwrite,
    output logic [ADDR_WIDTH-1:0] o_mem_paddr,
    output logic [DATA_WIDTH-1:0] o_mem_pwdata,
    input  logic [DATA_WIDTH-1:0] i_mem_prdata,
    input  logic                  i_mem_pready
);

    cache_if #(
        .DATA_WIDTH     (DATA_WIDTH),
        .ADDR_WIDTH     (ADDR_WIDTH),
        .CACHE_SIZE     (CACHE_SIZE),
        .CACHE_LINE_SIZE(CACHE_LINE_SIZE)
    ) u_cache_if ();

    cache_ctrl #(
        .DATA_WIDTH     (DATA_WIDTH),
        .ADDR_WIDTH     (ADDR_WIDTH),
        .CACHE_SIZE     (CACHE_SIZE),
        .CACHE_LINE_SIZE(CACHE_LINE_SIZE)
    ) u_cache_ctrl (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .o_mem_psel   (o_mem_psel),
        .o_mem_penable(o_mem_penable),
        .o_mem_pwrite (o_mem_pwrite),
        .o_mem_paddr  (o_mem_paddr),
        .o_mem_pwdata (o_mem_pwdata),
        .i_mem_prdata (i_mem_prdata),
        .i_mem_pready (i_mem_pready),
        .bus          (u_cache_if.ctrl)
    );

    cache #(
        .DATA_WIDTH     (DATA_WIDTH),
        .ADDR_WIDTH     (ADDR_WIDTH),
        .CACHE_SIZE     (CACHE_SIZE),
        .CACHE_LINE_SIZE(CACHE_LINE_SIZE)
    ) u_cache (
        .clk  (clk),
        .n_rst(n_rst),
        .bus  (u_cache_if.array)
    );

endmodule

/* source/cache_ctrl.sv */
// Cache controller

`timescale 1ns/1ps

module cache_ctrl import apb_pkg::*, cache_pkg::*; #(
    parameter DATA_WIDTH      = 32,
    parameter ADDR_WIDTH      = 16,
    parameter CACHE_SIZE      = 256,
    parameter CACHE_LINE_SIZE = 16
) (
    input  logic                  clk,
    input  logic                  n_rst,

    // CPU side APB slave
    input  logic                  i_psel,
    input  logic                  i_penable,
    input  logic                  i_pwrite,
    input  logic [ADDR_WIDTH-1:0] i_paddr,
    input  logic [DATA_WIDTH-1:0] i_pwdata,
    output logic [DATA_WIDTH-1:0] o_prdata,
    output logic                  o_pready,
    output logic                  o_pslverr,

    // memory side APB master
    output logic                  o_mem_psel,
    output logic                  o_mem_penable,
    output logic                  o_mem_pwrite,
    output logic [ADDR_WIDTH-1:0] o_mem_paddr,
    output logic [DATA_WIDTH-1:0] o_mem_pwdata,
    input  logic [DATA_WIDTH-1:0] i_mem_prdata,
    input  logic                  i_mem_pready,

    cache_if.ctrl                 bus
);

    localparam WORD_SIZE      = DATA_WIDTH / 8;
    localparam BYTE_BITS      = $clog2(WORD_SIZE);
    localparam INDEX_COUNT    = CACHE_SIZE / CACHE_LINE_SIZE;
    localparam OFFSET_WIDTH   = $clog2(CACHE_LINE_SIZE);
    localparam INDEX_WIDTH    = $clog2(INDEX_COUNT);
    localparam TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam LINE_WIDTH     = CACHE_LINE_SIZE * 8;
    localparam WORDS_PER_LINE = CACHE_LINE_SIZE / WORD_SIZE;
    localparam BEAT_WIDTH     = $clog2(WORDS_PER_LINE);

    ctrl_state_t             state;
    apb_phase_t              mem_phase;
    logic [BEAT_WIDTH-1:0]   beat;

    logic [ADDR_WIDTH-1:0]   addr_q;
    logic [DATA_WIDTH-1:0]   wdata_q;
    logic                    write_q;
    logic [DATA_WIDTH-1:0]   prdata_q;
    logic [TAG_WIDTH-1:0]    vtag_q;
    logic [LINE_WIDTH-1:0]   line_q;

    logic                    setup;
    logic                    unaligned;
    logic                    mem_done;
    logic                    last_beat;
    logic [ADDR_WIDTH-1:0]   cur_addr;
    logic [TAG_WIDTH-1:0]    cur_tag;
    logic [INDEX_WIDTH-1:0]  cur_index;
    logic [OFFSET_WIDTH-1:0] cur_offset;

    assign setup     = i_psel && !i_penable;
    assign unaligned = |i_paddr[BYTE_BITS-1:0];
    assign mem_done  = (mem_phase == PH_ACCESS) && i_mem_pready;
    assign last_beat = (beat == BEAT_WIDTH'(WORDS_PER_LINE - 1));

    // the lookup starts in the setup cycle, before the address is latched
    assign cur_addr   = (state == S_IDLE) ? i_paddr : addr_q;
    assign cur_tag    = cur_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign cur_index  = cur_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign cur_offset = cur_addr[OFFSET_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state     <= S_IDLE;
            mem_phase <= PH_IDLE;
            beat      <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (setup) begin
                        state <= unaligned ? S_ERROR : S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (bus.hit) begin
                        state <= S_RESPOND;
                    end else begin
                        beat      <= '0;
                        mem_phase <= PH_SETUP;
                        state     <= bus.dirty ? S_WB_BEAT : S_FILL_BEAT;
                    end
                end
                S_WB_BEAT, S_FILL_BEAT: begin
                    if (mem_phase == PH_SETUP) begin
                        mem_phase <= PH_ACCESS;
                    end else if (mem_done) begin
                        // beat wraps back to zero after the last word
                        beat      <= beat + 1'b1;
                        mem_phase <= PH_SETUP;
                        if (last_beat && state == S_WB_BEAT) begin
                            state <= S_FILL_BEAT;
                        end else if (last_beat) begin
                            state     <= S_FILL_WRITE;
                            mem_phase <= PH_IDLE;
                        end
                    end
                end
                S_FILL_WRITE: begin
                    // two cycles here, fe first and then re, so that LOOKUP sees the new line
                    if (!beat[0]) begin
                        beat <= BEAT_WIDTH'(1);
                    end else begin
                        beat  <= '0;
                        state <= S_LOOKUP;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && setup) begin
            addr_q  <= i_paddr;
            wdata_q <= i_pwdata;
            write_q <= i_pwrite;
        end
        if (state == S_LOOKUP && bus.hit && !write_q) begin
            prdata_q <= bus.rdata;
        end
        // the victim is captured on every miss and only sent out when dirty
        if (state == S_LOOKUP && !bus.hit) begin
            vtag_q <= bus.vtag;
            line_q <= bus.vdata;
        end
        if (state == S_FILL_BEAT && mem_done) begin
            line_q[beat*DATA_WIDTH +: DATA_WIDTH] <= i_mem_prdata;
        end
    end

    always_comb begin
        bus.re = (state == S_IDLE && setup && !unaligned) || (state == S_FILL_WRITE && beat[0]);
        bus.we = (state == S_LOOKUP) && bus.hit && write_q;
        bus.fe = (state == S_FILL_WRITE) && !beat[0];
    end

    assign bus.fill_valid = 1'b1;
    assign bus.fill_dirty = 1'b0;
    assign bus.tag        = cur_tag;
    assign bus.index      = cur_index;
    assign bus.offset     = cur_offset;
    assign bus.fdata      = line_q;
    assign bus.wdata      = wdata_q;

    assign o_prdata  = prdata_q;
    assign o_pready  = (state == S_RESPOND) || (state == S_ERROR);
    assign o_pslverr = (state == S_ERROR);

    // writeback addresses come from the victim tag, fill addresses from the CPU tag
    assign o_mem_psel    = (mem_phase != PH_IDLE);
    assign o_mem_penable = (mem_phase == PH_ACCESS);
    assign o_mem_pwrite  = (state == S_WB_BEAT);
    assign o_mem_paddr   = (state == S_WB_BEAT) ?
                           {vtag_q, cur_index, beat, {BYTE_BITS{1'b0}}} :
                           {cur_tag, cur_index, beat, {BYTE_BITS{1'b0}}};
    assign o_mem_pwdata  = line_q[beat*DATA_WIDTH +: DATA_WIDTH];

    a_pready_in_access: assert property (
        @(posedge clk) disable iff (!n_rst) o_pready |-> (i_psel && i_penable)
    ) else $error("cache_ctrl: pready outside an APB access phase");

    a_mem_stable: assert property (
        @(posedge clk) disable iff (!n_rst)
        (o_mem_penable && !i_mem_pready) |=> ($stable(o_mem_paddr) && $stable(o_mem_pwdata))
    ) else $error("cache_ctrl: memory address or data changed during a wait state");

endmodule

/* source/cache.sv */
// Direct-mapped cache array

`timescale 1ns/1ps

module cache import cache_pkg::*; #(
    parameter DATA_WIDTH      = 32,
    parameter ADDR_WIDTH      = 16,
    parameter CACHE_SIZE      = 256,
    parameter CACHE_LINE_SIZE = 16
) (
    input  logic   clk,
    input  logic   n_rst,
    cache_if.array bus
);

    localparam WORD_SIZE    = DATA_WIDTH / 8;
    localparam BYTE_BITS    = $clog2(WORD_SIZE);
    localparam INDEX_COUNT  = CACHE_SIZE / CACHE_LINE_SIZE;
    localparam OFFSET_WIDTH = $clog2(CACHE_LINE_SIZE);
    localparam INDEX_WIDTH  = $clog2(INDEX_COUNT);
    localparam TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam LINE_WIDTH   = CACHE_LINE_SIZE * 8;
    localparam SEL_WIDTH    = OFFSET_WIDTH - BYTE_BITS;

    cache_state_t                line_state [INDEX_COUNT];
    cache_state_t                cur_state;
    logic                        line_hit;
    logic                        write_hit;
    logic [SEL_WIDTH-1:0]        word_sel;

    logic                        ram_re;
    logic                        data_ram_we;
    logic [LINE_WIDTH-1:0]       data_rd;
    logic [LINE_WIDTH-1:0]       data_wr;
    logic [TAG_WIDTH-1:0]        tag_rd;

    // the state is looked up with the index of the current cycle, the tag with the
    // registered RAM output, so the index must be held for the cycle after an enable
    assign cur_state = line_state[bus.index];
    assign line_hit  = cur_state.valid && (tag_rd == bus.tag);
    assign write_hit = bus.we && line_hit;
    assign word_sel  = bus.offset[OFFSET_WIDTH-1:BYTE_BITS];

    // every access reads the line out, which also makes it the victim on a miss
    assign ram_re      = bus.re || bus.we || bus.fe;
    assign data_ram_we = write_hit || bus.fe;

    assign bus.hit   = line_hit;
    assign bus.dirty = cur_state.valid && cur_state.dirty;
    assign bus.vtag  = tag_rd;
    assign bus.vdata = data_rd;
    assign bus.rdata = data_rd[word_sel*DATA_WIDTH +: DATA_WIDTH];

    // a fill replaces the whole line, a write merges one word into the line read before
    always_comb begin
        data_wr = data_rd;
        if (bus.fe) begin
            data_wr = bus.fdata;
        end else if (write_hit) begin
            data_wr[word_sel*DATA_WIDTH +: DATA_WIDTH] = bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            for (int i = 0; i < INDEX_COUNT; i++) begin
                line_state[i] <= '0;
            end
        end else if (bus.fe) begin
            line_state[bus.index] <= '{valid: bus.fill_valid, dirty: bus.fill_dirty};
        end else if (write_hit) begin
            line_state[bus.index].dirty <= 1'b1;
        end
    end

    dp_ram #(
        .DATA_WIDTH(LINE_WIDTH),
        .RAM_DEPTH (INDEX_COUNT)
    ) data_ram (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_ram_rd_en  (ram_re),
        .i_ram_rd_addr(bus.index),
        .o_ram_rd_data(data_rd),
        .i_ram_wr_en  (data_ram_we),
        .i_ram_wr_addr(bus.index),
        .i_ram_wr_data(data_wr)
    );

    dp_ram #(
        .DATA_WIDTH(TAG_WIDTH),
        .RAM_DEPTH (INDEX_COUNT)
    ) tag_ram (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_ram_rd_en  (ram_re),
        .i_ram_rd_addr(bus.index),
        .o_ram_rd_data(tag_rd),
        .i_ram_wr_en  (bus.fe),
        .i_ram_wr_addr(bus.index),
        .i_ram_wr_data(bus.tag)
    );

    // the controller must never overlap read, write and fill requests
    a_one_request: assert property (
        @(posedge clk) disable iff (!n_rst) $onehot0({bus.re, bus.we, bus.fe})
    ) else $error("cache: more than one of re, we and fe in one cycle");

endmodule

/* source/dp_ram.sv */
// Simple dual port RAM

`timescale 1ns/1ps

module dp_ram #(
    parameter DATA_WIDTH = 32,
    parameter RAM_DEPTH  = 16
) (
    input  logic                         clk,
    input  logic                         n_rst,
    input  logic                         i_ram_rd_en,
    input  logic [$clog2(RAM_DEPTH)-1:0] i_ram_rd_addr,
    output logic [DATA_WIDTH-1:0]        o_ram_rd_data,
    input  logic                         i_ram_wr_en,
    input  logic [$clog2(RAM_DEPTH)-1:0] i_ram_wr_addr,
    input  logic [DATA_WIDTH-1:0]        i_ram_wr_data
);

    logic [DATA_WIDTH-1:0] mem [RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (i_ram_wr_en) begin
            mem[i_ram_wr_addr] <= i_ram_wr_data;
        end
    end

    // read data holds its value while read enable is low
    // a read and a write to the same address in one cycle return the old contents
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_ram_rd_data <= '0;
        end else if (i_ram_rd_en) begin
            o_ram_rd_data <= mem[i_ram_rd_addr];
        end
    end

endmodule

/* source/cache_if.sv */
// Controller to cache array interface

`timescale 1ns/1ps

interface cache_if #(
    parameter DATA_WIDTH      = 32,
    parameter ADDR_WIDTH      = 16,
    parameter CACHE_SIZE      = 256,
    parameter CACHE_LINE_SIZE = 16
);

    localparam INDEX_COUNT  = CACHE_SIZE / CACHE_LINE_SIZE;
    localparam OFFSET_WIDTH = $clog2(CACHE_LINE_SIZE);
    localparam INDEX_WIDTH  = $clog2(INDEX_COUNT);
    localparam TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam LINE_WIDTH   = CACHE_LINE_SIZE * 8;

    // request side
    logic                    re;
    logic                    we;
    logic                    fe;
    logic                    fill_valid;
    logic                    fill_dirty;
    logic [OFFSET_WIDTH-1:0] offset;
    logic [INDEX_WIDTH-1:0]  index;
    logic [TAG_WIDTH-1:0]    tag;
    logic [LINE_WIDTH-1:0]   fdata;
    logic [DATA_WIDTH-1:0]   wdata;

    // these are valid one cycle after an enable
    logic                    hit;
    logic                    dirty;
    logic [TAG_WIDTH-1:0]    vtag;
    logic [LINE_WIDTH-1:0]   vdata;
    logic [DATA_WIDTH-1:0]   rdata;

    modport ctrl (
        output re, we, fe, fill_valid, fill_dirty, offset, index, tag, fdata, wdata,
        input  hit, dirty, vtag, vdata, rdata
    );

    modport array (
        input  re, we, fe, fill_valid, fill_dirty, offset, index, tag, fdata, wdata,
        output hit, dirty, vtag, vdata, rdata
    );

endinterface

/* source/cache_pkg.sv */
// Cache line state and controller states

package cache_pkg;

    // state kept per index next to the tag and data RAMs
    typedef struct packed {
        logic valid;
        logic dirty;
    } cache_state_t;

    // miss handling runs WB_BEAT only for a dirty victim, then FILL_BEAT and FILL_WRITE,
    // and then goes back to LOOKUP
    typedef enum logic [2:0] {
        S_IDLE       = 3'd0,
        S_LOOKUP     = 3'd1,
        S_RESPOND    = 3'd2,
        S_WB_BEAT    = 3'd3,
        S_FILL_BEAT  = 3'd4,
        S_FILL_WRITE = 3'd5,
        S_ERROR      = 3'd6
    } ctrl_state_t;

endpackage

/* source/apb_pkg.sv */
// APB transfer phases

package apb_pkg;

    // a master sits in SETUP for one cycle and then in ACCESS until pready
    typedef enum logic [1:0] {
        PH_IDLE   = 2'd0,
        PH_SETUP  = 2'd1,
        PH_ACCESS = 2'd2
    } apb_phase_t;

endpackage
